// ==== common/snax_mem_pkg.sv ====
// scratchpad word and address widths and the request and response structs; no byte enables
package snax_mem_pkg;

  // width of one scratchpad word in bits
  parameter int data_w = 32;

  // word address width, enough for a full 256 word bank
  parameter int addr_w = 8;

  // one memory access as a requester presents it to the arbiter
  // req is a level that stays high with all other fields unchanged
  // until the cycle the requester sees its grant
  typedef struct packed {
    logic              req;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } mem_req_t;

  // read response, valid pulses for one cycle one cycle after the granted read
  // writes never produce a response
  typedef struct packed {
    logic              valid;
    logic [data_w-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== common/snax_norm_pkg.sv ====
// normalization job descriptor and engine states; job addresses wrap at the bank size
package snax_norm_pkg;

  // one block job, the count is one bit wider than an address
  // so that a job over the whole bank can be described
  typedef struct packed {
    logic [snax_mem_pkg::addr_w-1:0] src;
    logic [snax_mem_pkg::addr_w-1:0] dst;
    logic [snax_mem_pkg::addr_w:0]   count;
  } norm_job_t;

  // engine sequence per word is read_req, read_wait, write_req
  // finish emits done once the last word has been written
  typedef enum logic [2:0] {
    idle,
    read_req,
    read_wait,
    write_req,
    finish
  } norm_state_e;

endpackage

// ==== rtl/lzc_snax.sv ====
// zero counter for width of at least 2; cnt has no meaning while empty is high
`timescale 1ns/1ps

module lzc_snax #(
  // number of input bits
  parameter int width = 2,
  // 0 counts trailing zeros from bit 0, 1 counts leading zeros from the top bit
  parameter bit mode = 1'b0
) (
  input  logic [width-1:0]         in,
  output logic [$clog2(width)-1:0] cnt,
  // high when no input bit is set
  output logic                     empty
);

  // depth of the select tree
  localparam int levels = $clog2(width);
  // input rounded up to a full power of two
  localparam int pad_w = 2 ** levels;

  // input in search order, padded with zeros that never win
  logic [pad_w-1:0] in_pad;

  // node n has children 2n+1 and 2n+2, the root is node 0
  // node_vld says a set bit exists below the node, node_idx says where the first one is
  logic [pad_w-2:0]             node_vld;
  logic [pad_w-2:0][levels-1:0] node_idx;

  // in leading-zero mode the top bit is searched first, so the vector is reversed
  always_comb begin
    in_pad = '0;
    for (int i = 0; i < width; i++) begin
      in_pad[i] = mode ? in[width-1-i] : in[i];
    end
  end

  for (genvar l = 0; l < levels; l++) begin : g_level
    for (genvar k = 0; k < 2 ** l; k++) begin : g_node
      if (l == levels - 1) begin : g_leaf
        // a leaf looks at one pair of input bits, the lower bit wins
        assign node_vld[2**l-1+k] = in_pad[2*k] | in_pad[2*k+1];
        assign node_idx[2**l-1+k] = in_pad[2*k] ? levels'(2 * k) : levels'(2 * k + 1);
      end else begin : g_inner
        // an inner node prefers its lower child whenever that child holds a set bit
        assign node_vld[2**l-1+k] = node_vld[2**(l+1)-1+2*k] | node_vld[2**(l+1)+2*k];
        assign node_idx[2**l-1+k] = node_vld[2**(l+1)-1+2*k] ? node_idx[2**(l+1)-1+2*k]
                                                             : node_idx[2**(l+1)+2*k];
      end
    end
  end

  // the root holds the position of the first set bit in search order
  assign cnt   = node_idx[0];
  assign empty = ~node_vld[0];

endmodule

// ==== rtl/rr_arbiter.sv ====
// round-robin arbiter for num_req of at least 2; grant is combinational and lasts one cycle
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int num_req = 2
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  snax_mem_pkg::mem_req_t req [num_req],
  output logic [num_req-1:0]     gnt,
  output snax_mem_pkg::mem_req_t mem_req
);

  localparam int idx_w = $clog2(num_req);

  // port that was granted last, the search starts at the port after it
  logic [idx_w-1:0] ptr;

  // request levels in port order and rotated so the port after ptr sits at bit 0
  logic [num_req-1:0] req_lvl;
  logic [num_req-1:0] req_rot;

  // distance of the winner from the search start and its port index
  logic [idx_w-1:0] win_ofs;
  logic [idx_w-1:0] win_idx;
  logic             none_active;

  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      req_lvl[i] = req[i].req;
    end
  end

  // circular rotation, written with a modulo so num_req need not be a power of two
  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      req_rot[i] = req_lvl[(int'(ptr) + 1 + i) % num_req];
    end
  end

  // first active request in circular order is the lowest set bit of the rotated vector
  lzc_snax #(
    .width (num_req),
    .mode  (1'b0)
  ) winner_lzc (
    .in    (req_rot),
    .cnt   (win_ofs),
    .empty (none_active)
  );

  // rotate the offset back into a port index
  assign win_idx = idx_w'((int'(ptr) + 1 + int'(win_ofs)) % num_req);

  always_comb begin
    gnt = '0;
    if (!none_active) begin
      gnt[win_idx] = 1'b1;
    end
  end

  // the bank sees an inactive request when nobody asks
  assign mem_req = none_active ? '0 : req[win_idx];

  // after reset the pointer names the last port, so port 0 gets the first grant
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ptr <= idx_w'(num_req - 1);
    end else if (!none_active) begin
      ptr <= win_idx;
    end
  end

endmodule

// ==== rtl/spm_bank.sv ====
// single-port scratchpad, one access per cycle; memory contents are unknown after power-up
`timescale 1ns/1ps

module spm_bank #(
  parameter int depth = 256
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  snax_mem_pkg::mem_req_t mem_req,
  output snax_mem_pkg::mem_rsp_t mem_rsp
);

  localparam int aw = $clog2(depth);

  logic [snax_mem_pkg::data_w-1:0] mem [depth];

  // the read port registers its data, valid marks the cycle it is usable
  logic                            rd_valid;
  logic [snax_mem_pkg::data_w-1:0] rd_data;

  // a write lands in its request cycle, a read samples the array at the same edge
  always_ff @(posedge clk) begin
    if (mem_req.req) begin
      if (mem_req.we) begin
        mem[mem_req.addr[aw-1:0]] <= mem_req.wdata;
      end else begin
        rd_data <= mem[mem_req.addr[aw-1:0]];
      end
    end
  end

  // valid is a single cycle pulse for every granted read
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= mem_req.req & ~mem_req.we;
    end
  end

  assign mem_rsp = '{valid: rd_valid, rdata: rd_data};

endmodule

// ==== norm_engine/norm_engine.sv ====
// block normalization engine; expects read data exactly one cycle after its read grant
`timescale 1ns/1ps

module norm_engine (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          start,
  input  snax_norm_pkg::norm_job_t      job,
  output snax_mem_pkg::mem_req_t        mem_req,
  input  logic                          gnt,
  input  snax_mem_pkg::mem_rsp_t        mem_rsp,
  output logic                          busy,
  output logic                          done,
  output logic [snax_mem_pkg::addr_w:0] zero_cnt
);

  snax_norm_pkg::norm_state_e state;

  // job as it was when start was accepted
  snax_norm_pkg::norm_job_t job_q;

  // word index within the block, wide enough to count a full bank
  logic [snax_mem_pkg::addr_w:0] idx;

  // normalized word waiting for its write grant
  logic [snax_mem_pkg::data_w-1:0] result;

  // leading zero count of the word coming back from the bank
  logic [$clog2(snax_mem_pkg::data_w)-1:0] lz_cnt;
  logic                                    lz_empty;

  logic last_word;

  lzc_snax #(
    .width (snax_mem_pkg::data_w),
    .mode  (1'b1)
  ) word_lzc (
    .in    (mem_rsp.rdata),
    .cnt   (lz_cnt),
    .empty (lz_empty)
  );

  assign last_word = (idx == job_q.count - 1'b1);

  // control path
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= snax_norm_pkg::idle;
      busy     <= 1'b0;
      done     <= 1'b0;
      idx      <= '0;
      zero_cnt <= '0;
    end else begin
      // done only ever lasts one cycle
      done <= 1'b0;
      case (state)
        snax_norm_pkg::idle: begin
          // start is only looked at here, so a pulse while busy has no effect
          if (start) begin
            busy     <= 1'b1;
            idx      <= '0;
            zero_cnt <= '0;
            // an empty job goes straight to done
            state    <= (job.count == '0) ? snax_norm_pkg::finish : snax_norm_pkg::read_req;
          end
        end
        snax_norm_pkg::read_req: begin
          if (gnt) begin
            state <= snax_norm_pkg::read_wait;
          end
        end
        snax_norm_pkg::read_wait: begin
          // the word is counted in the cycle its data shows up
          if (mem_rsp.valid) begin
            if (lz_empty) begin
              zero_cnt <= zero_cnt + 1'b1;
            end
            state <= snax_norm_pkg::write_req;
          end
        end
        snax_norm_pkg::write_req: begin
          if (gnt) begin
            idx   <= idx + 1'b1;
            state <= last_word ? snax_norm_pkg::finish : snax_norm_pkg::read_req;
          end
        end
        snax_norm_pkg::finish: begin
          // busy falls on the same edge that raises done
          busy  <= 1'b0;
          done  <= 1'b1;
          state <= snax_norm_pkg::idle;
        end
        default: begin
          state <= snax_norm_pkg::idle;
        end
      endcase
    end
  end

  // data path registers
  always_ff @(posedge clk) begin
    if (state == snax_norm_pkg::idle && start) begin
      job_q <= job;
    end
    // shifting by the leading zero count puts the first set bit at the top
    // an all-zero word would get an undefined count, so it is forced to zero
    if (state == snax_norm_pkg::read_wait && mem_rsp.valid) begin
      result <= lz_empty ? '0 : (mem_rsp.rdata << lz_cnt);
    end
  end

  // the request is a level tied to the state, so it holds until the grant moves the state on
  always_comb begin
    mem_req = '0;
    case (state)
      snax_norm_pkg::read_req: begin
        mem_req.req  = 1'b1;
        mem_req.addr = job_q.src + idx[snax_mem_pkg::addr_w-1:0];
      end
      snax_norm_pkg::write_req: begin
        mem_req.req   = 1'b1;
        mem_req.we    = 1'b1;
        mem_req.addr  = job_q.dst + idx[snax_mem_pkg::addr_w-1:0];
        mem_req.wdata = result;
      end
      default: begin
        mem_req = '0;
      end
    endcase
  end

endmodule

// ==== rtl/norm_spm_top.sv ====
// host on arbiter port 0 and engine on port 1; extra ports above 1 are tied inactive
`timescale 1ns/1ps

module norm_spm_top #(
  parameter int num_req = 2,
  parameter int depth   = 256
) (
  input  logic                          clk,
  input  logic                          arst_n,
  input  snax_mem_pkg::mem_req_t        host_req,
  output logic                          host_gnt,
  output snax_mem_pkg::mem_rsp_t        host_rsp,
  input  logic                          start,
  input  snax_norm_pkg::norm_job_t      job,
  output logic                          busy,
  output logic                          done,
  output logic [snax_mem_pkg::addr_w:0] zero_cnt
);

  snax_mem_pkg::mem_req_t arb_req [num_req];
  snax_mem_pkg::mem_req_t bank_req;
  snax_mem_pkg::mem_rsp_t bank_rsp;
  snax_mem_pkg::mem_req_t eng_req;
  snax_mem_pkg::mem_rsp_t eng_rsp;

  logic [num_req-1:0] gnt;
  // grant of the previous cycle, tells whose read the bank is answering
  logic [num_req-1:0] gnt_q;

  assign arb_req[0] = host_req;
  assign arb_req[1] = eng_req;

  for (genvar p = 2; p < num_req; p++) begin : g_unused_port
    assign arb_req[p] = '0;
  end

  rr_arbiter #(
    .num_req (num_req)
  ) arb (
    .clk     (clk),
    .arst_n  (arst_n),
    .req     (arb_req),
    .gnt     (gnt),
    .mem_req (bank_req)
  );

  spm_bank #(
    .depth (depth)
  ) bank (
    .clk     (clk),
    .arst_n  (arst_n),
    .mem_req (bank_req),
    .mem_rsp (bank_rsp)
  );

  norm_engine engine (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (start),
    .job      (job),
    .mem_req  (eng_req),
    .gnt      (gnt[1]),
    .mem_rsp  (eng_rsp),
    .busy     (busy),
    .done     (done),
    .zero_cnt (zero_cnt)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      gnt_q <= '0;
    end else begin
      gnt_q <= gnt;
    end
  end

  // read data is shared, only the valid bit is steered to the requester that was granted
  assign host_gnt = gnt[0];
  assign host_rsp = '{valid: bank_rsp.valid & gnt_q[0], rdata: bank_rsp.rdata};
  assign eng_rsp  = '{valid: bank_rsp.valid & gnt_q[1], rdata: bank_rsp.rdata};

endmodule

// ==== verification/norm_spm_checker.sv ====
// assumes the host on arbiter port 0 and the engine on port 1, as wired in the top level
`timescale 1ns/1ps

module norm_spm_checker #(
  parameter int num_req = 2
) (
  input logic                   clk,
  input logic                   arst_n,
  input snax_mem_pkg::mem_req_t arb_req [num_req],
  input logic [num_req-1:0]     gnt,
  input snax_mem_pkg::mem_rsp_t bank_rsp,
  input logic                   busy
);

  // request levels gathered from the arbiter inputs in port order
  logic [num_req-1:0] req_lvl;
  // ports whose pending request is a read
  logic [num_req-1:0] rd_lvl;
  // one of the ports had its read granted in this cycle
  logic               gnt_rd;

  always_comb begin
    for (int i = 0; i < num_req; i++) begin
      req_lvl[i] = arb_req[i].req;
      rd_lvl[i]  = arb_req[i].req & ~arb_req[i].we;
    end
  end

  assign gnt_rd = |(gnt & rd_lvl);

  // only one port may own the bank in a cycle
  a_gnt_onehot: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(gnt))
    else $error("grant vector %b is not one-hot or zero", gnt);

  // a grant without a request would hand the bank a stale access
  a_gnt_req: assert property (@(posedge clk) disable iff (!arst_n) (gnt & ~req_lvl) == '0)
    else $error("grant %b given to a port that is not requesting %b", gnt, req_lvl);

  // read data comes back exactly one cycle after the granted read
  a_rsp_after_rd: assert property (@(posedge clk) disable iff (!arst_n)
    gnt_rd |=> bank_rsp.valid)
    else $error("response valid missing one cycle after a granted read");

  a_rsp_only_rd: assert property (@(posedge clk) disable iff (!arst_n)
    bank_rsp.valid |-> $past(gnt_rd))
    else $error("response valid without a granted read in the cycle before");

  // the engine stays quiet while the reset is applied
  a_rst_quiet: assert property (@(posedge clk) !arst_n |-> (!arb_req[1].req && !busy))
    else $error("engine request or busy high during reset");

endmodule

// ==== verification/norm_spm_tb.sv ====
// sources use 0x00..0x2f, results 0x40..0xaf, host data 0xc0..0xcf and the guard 0xe0..0xe3
`timescale 1ns/1ps

module norm_spm_tb;

  localparam int num_rows = 3;

  logic                          clk;
  logic                          arst_n;
  snax_mem_pkg::mem_req_t        host_req;
  logic                          host_gnt;
  snax_mem_pkg::mem_rsp_t        host_rsp;
  logic                          start;
  snax_norm_pkg::norm_job_t      job;
  logic                          busy;
  logic                          done;
  logic [snax_mem_pkg::addr_w:0] zero_cnt;

  // each row holds a name, the job as {src, dst, count}, a fill kind (0 explicit, 1 sparse
  // with zero words, 2 random), host traffic while busy and a second start tried while busy
  string                    row_name    [num_rows] = '{"explicit", "zeros", "random_long"};
  snax_norm_pkg::norm_job_t row_job     [num_rows] = '{{8'h00, 8'h40, 9'd8},
                                                      {8'h10, 8'h50, 9'd12},
                                                      {8'h00, 8'h80, 9'd48}};
  int                       row_pat     [num_rows] = '{0, 1, 2};
  bit                       row_host    [num_rows] = '{1'b0, 1'b1, 1'b1};
  bit                       row_restart [num_rows] = '{1'b0, 1'b1, 1'b0};

  // top bit already set, only bit zero set, and a few ordinary words
  logic [31:0] explicit_words [8] = '{32'h8000_0000, 32'h0000_0001, 32'h0012_3400,
                                      32'h7fff_ffff, 32'h0000_8000, 32'h4000_0001,
                                      32'h00f0_000f, 32'h0000_0003};

  logic [31:0] expected [256];
  int          errors = 0;
  int          cycles = 0;
  int          limit = 200;
  int          done_count = 0;
  int          seed;

  norm_spm_top #(
    .num_req (2),
    .depth   (256)
  ) norm_spm_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .host_req (host_req),
    .host_gnt (host_gnt),
    .host_rsp (host_rsp),
    .start    (start),
    .job      (job),
    .busy     (busy),
    .done     (done),
    .zero_cnt (zero_cnt)
  );

  bind norm_spm_top norm_spm_checker #(
    .num_req (num_req)
  ) checker_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .arb_req  (arb_req),
    .gnt      (gnt),
    .bank_rsp (bank_rsp),
    .busy     (busy)
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("sim failed");
      $finish;
    end
  end

  // done is counted at the falling edge, where the one cycle pulse is stable
  always @(negedge clk) begin
    if (done) begin
      done_count++;
    end
  end

  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {8'h5a, a, ~a, a ^ 8'h3c};
  endfunction

  // shift left until the top bit is set and leave an all-zero word at zero
  function automatic logic [31:0] normalize(input logic [31:0] w);
    logic [31:0] r;
    r = w;
    if (r != '0) begin
      while (!r[31]) begin
        r = r << 1;
      end
    end
    return r;
  endfunction

  // called 2 ns after a rising edge and returns 2 ns after one
  task automatic host_access(input logic we, input logic [7:0] addr, input logic [31:0] wdata,
                             output logic [31:0] rdata);
    int waits;
    waits = 0;
    rdata = '0;
    host_req = '{req: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!host_gnt) begin
      waits++;
      @(negedge clk);
    end
    if (waits > 1) begin
      errors++;
      $display("host request at %h waited %0d cycles for its grant", addr, waits);
    end
    if (host_rsp.valid) begin
      errors++;
      $display("host read valid was already high in the grant cycle at %h", addr);
    end
    @(posedge clk);
    #2;
    host_req = '0;
    if (!we) begin
      @(negedge clk);
      if (!host_rsp.valid) begin
        errors++;
        $display("host read valid missing one cycle after the grant at %h", addr);
      end
      rdata = host_rsp.rdata;
      @(posedge clk);
      #2;
    end
  endtask

  task automatic read_expect(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] data;
    host_access(1'b0, addr, '0, data);
    if (data !== exp) begin
      errors++;
      $display("FAILED %s at %h expected %h actual %h", name, addr, exp, data);
    end
  endtask

  initial begin
    logic [31:0] word;
    logic [31:0] unused;
    int          base;
    int          k;
    int          model_zeros;
    seed = 32'hf6a5;
    for (int r = 0; r < num_rows; r++) begin
      limit += 8 * int'(row_job[r].count);
    end
    arst_n   = 1'b0;
    host_req = '0;
    start    = 1'b0;
    job      = '0;
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;

    // fill the host region and the guard block, then read a few words back
    for (int a = 'hc0; a < 'he4; a++) begin
      host_access(1'b1, 8'(a), fill_word(8'(a)), unused);
    end
    for (int a = 'hc0; a < 'hc4; a++) begin
      read_expect("host_write_read", 8'(a), fill_word(8'(a)));
    end

    for (int r = 0; r < num_rows; r++) begin
      model_zeros = 0;
      for (int i = 0; i < int'(row_job[r].count); i++) begin
        case (row_pat[r])
          0: word = explicit_words[i % 8];
          1: word = (i % 3 == 0) ? 32'h0 : (32'h1 << (2 * i));
          default: word = $random(seed);
        endcase
        expected[i] = normalize(word);
        if (word == '0) begin
          model_zeros++;
        end
        host_access(1'b1, row_job[r].src + 8'(i), word, unused);
      end

      base  = done_count;
      start = 1'b1;
      job   = row_job[r];
      @(posedge clk);
      #2;
      start = 1'b0;
      // the engine is busy by now, so this second job must never run
      if (row_restart[r]) begin
        start = 1'b1;
        job   = {8'h00, 8'he0, 9'd4};
        @(posedge clk);
        #2;
        start = 1'b0;
      end
      // the host keeps reading its own region while the engine runs
      k = 0;
      while (row_host[r] && done_count == base) begin
        read_expect({row_name[r], "_host"}, 8'hc0 + 8'(k % 16), fill_word(8'hc0 + 8'(k % 16)));
        k++;
      end
      while (done_count == base) begin
        @(posedge clk);
        #2;
      end

      if (zero_cnt !== 9'(model_zeros)) begin
        errors++;
        $display("FAILED %s_zero_cnt expected %0d actual %0d", row_name[r], model_zeros, zero_cnt);
      end
      @(negedge clk);
      if (busy) begin
        errors++;
        $display("busy still high after done in %s", row_name[r]);
      end
      @(posedge clk);
      #2;

      for (int i = 0; i < int'(row_job[r].count); i++) begin
        read_expect(row_name[r], row_job[r].dst + 8'(i), expected[i]);
      end
      if (row_restart[r]) begin
        for (int a = 'he0; a < 'he4; a++) begin
          read_expect({row_name[r], "_guard"}, 8'(a), fill_word(8'(a)));
        end
      end
    end

    $display("%0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
common/snax_mem_pkg.sv
common/snax_norm_pkg.sv
rtl/lzc_snax.sv
rtl/rr_arbiter.sv
rtl/spm_bank.sv
norm_engine/norm_engine.sv
rtl/norm_spm_top.sv
verification/norm_spm_checker.sv
verification/norm_spm_tb.sv

// ==== Makefile ====
TOP = norm_spm_tb
LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean
